// ==== include/cpu_6s46_settings.svh ====
`ifndef CPU_6S46_SETTINGS_SVH
`define CPU_6S46_SETTINGS_SVH

// nibble RAM geometry
// 4 banks of 64 nibbles, 256 nibbles in all
`define CPU_RAM_BANKS 4
`define CPU_BANK_DEPTH 64

// savestate word map
// word 0 holds pc, a, b and the flags
`define CPU_SS_ADDR_REGS 0

// x and y share one word
`define CPU_SS_ADDR_XY 1

// first RAM word, 8 nibbles per word
`define CPU_SS_ADDR_RAM 2

`endif

// ==== source/cpu_6s46_pkg.sv ====
`default_nettype none

package cpu_6s46_pkg;

  // decoded operation
  typedef enum logic [2:0] {
    ld_ri,
    add_ri,
    jp,
    ld_x,
    ld_y,
    nop5,
    halt,
    illegal
  } opcode_e;

  typedef struct packed {
    logic [12:0] pc;
    logic [3:0]  a;
    logic [3:0]  b;
    logic [11:0] x;
    logic [11:0] y;
    logic        carry;
    logic        zero;
  } cpu_regs_t;

  // one nibble access from the core
  typedef struct packed {
    logic [7:0] addr;
    logic [3:0] wdata;
    logic       wren;
  } ram_req_t;

  // savestate word 0 layout
  function automatic logic [31:0] pack_regs_word(cpu_regs_t r);
    logic [31:0] w;
    w = '0;
    w[12:0] = r.pc;
    w[19:16] = r.a;
    w[23:20] = r.b;
    w[24] = r.carry;
    w[25] = r.zero;
    return w;
  endfunction

  // savestate word 1 layout
  function automatic logic [31:0] pack_xy_word(cpu_regs_t r);
    logic [31:0] w;
    w = '0;
    w[11:0] = r.x;
    w[27:16] = r.y;
    return w;
  endfunction

endpackage

`default_nettype wire

// ==== source/ram_bank.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_6s46_settings.svh"

module ram_bank #(
  parameter int bank_index = 0
) (
  input  wire                          clk,
  input  wire cpu_6s46_pkg::ram_req_t  core_req,
  input  wire                          ss_wren,
  input  wire [2:0]                    ss_row,
  input  wire [31:0]                   ss_word,
  output logic [4*`CPU_BANK_DEPTH-1:0] nibbles
);

  localparam int row_w = $clog2(`CPU_BANK_DEPTH);
  localparam int bank_w = 8 - row_w;
  localparam int ss_nibbles = 8;

  logic [3:0] mem [`CPU_BANK_DEPTH];
  logic       core_hit;

  // top address bits pick the bank
  assign core_hit = core_req.wren &&
                    (core_req.addr[7:row_w] == bank_w'(bank_index));

  always_ff @(posedge clk) begin
    if (core_hit) begin
      mem[core_req.addr[row_w-1:0]] <= core_req.wdata;
    end
    // savestate write lands last, so it wins a collision
    if (ss_wren) begin
      for (int i = 0; i < ss_nibbles; i++) begin
        mem[{ss_row, 3'(i)}] <= ss_word[4*i +: 4];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `CPU_BANK_DEPTH; i++) begin
      nibbles[4*i +: 4] = mem[i];
    end
  end

endmodule

`default_nettype wire

// ==== source/savestate_port.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_6s46_settings.svh"

module savestate_port (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire [7:0]                    ss_bus_addr,
  input  wire [31:0]                   ss_bus_in,
  input  wire                          ss_bus_wren,
  input  wire cpu_6s46_pkg::cpu_regs_t regs,
  input  wire [7:0]                    mem_addr,
  input  wire [4*`CPU_BANK_DEPTH-1:0]  bank_nibbles [`CPU_RAM_BANKS],
  output logic [31:0]                  ss_bus_out,
  output logic                         ss_regs_wren,
  output cpu_6s46_pkg::cpu_regs_t      ss_regs,
  output logic [`CPU_RAM_BANKS-1:0]    bank_ss_wren,
  output logic [2:0]                   ss_row,
  output logic [3:0]                   mem_rdata
);
  import cpu_6s46_pkg::*;

  localparam int nib_per_word = 8;
  localparam int words_per_bank = `CPU_BANK_DEPTH / nib_per_word;
  localparam int ram_words = `CPU_RAM_BANKS * words_per_bank;
  localparam int row_w = $clog2(`CPU_BANK_DEPTH);
  localparam int grp_w = $clog2(words_per_bank);
  localparam int bank_w = $clog2(`CPU_RAM_BANKS);

  logic [7:0]        ram_word;
  logic              is_regs;
  logic              is_xy;
  logic              is_ram;
  logic [bank_w-1:0] ram_bank_sel;
  logic [31:0]       rd_word;

  assign is_regs = (ss_bus_addr == 8'(`CPU_SS_ADDR_REGS));
  assign is_xy = (ss_bus_addr == 8'(`CPU_SS_ADDR_XY));
  assign ram_word = ss_bus_addr - 8'(`CPU_SS_ADDR_RAM);
  assign is_ram = (ss_bus_addr >= 8'(`CPU_SS_ADDR_RAM)) && (ram_word < 8'(ram_words));

  // word index splits into bank and 8-nibble row group
  assign ram_bank_sel = ram_word[grp_w +: bank_w];
  assign ss_row = ram_word[grp_w-1:0];

  always_comb begin
    for (int b = 0; b < `CPU_RAM_BANKS; b++) begin
      bank_ss_wren[b] = ss_bus_wren && is_ram && (ram_bank_sel == bank_w'(b));
    end
  end

  // merge the written word into the live register set
  assign ss_regs_wren = ss_bus_wren && (is_regs || is_xy);

  always_comb begin
    ss_regs = regs;
    if (is_regs) begin
      ss_regs.pc = ss_bus_in[12:0];
      ss_regs.a = ss_bus_in[19:16];
      ss_regs.b = ss_bus_in[23:20];
      ss_regs.carry = ss_bus_in[24];
      ss_regs.zero = ss_bus_in[25];
    end else if (is_xy) begin
      ss_regs.x = ss_bus_in[11:0];
      ss_regs.y = ss_bus_in[27:16];
    end
  end

  always_comb begin
    rd_word = '0;
    if (is_regs) begin
      rd_word = pack_regs_word(regs);
    end else if (is_xy) begin
      rd_word = pack_xy_word(regs);
    end else if (is_ram) begin
      rd_word = bank_nibbles[ram_bank_sel][32*ss_row +: 32];
    end
  end

  always_ff @(posedge clk) begin
    if (reset_n) begin
      ss_bus_out <= '0;
    end else begin
      ss_bus_out <= rd_word;
    end
  end

  // core read nibble
  assign mem_rdata = bank_nibbles[mem_addr[7:row_w]][4*mem_addr[row_w-1:0] +: 4];

endmodule

`default_nettype wire

// ==== source/cpu_6s46_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_6s46_core (
  input  wire                     clk,
  input  wire                     reset_n,
  input  wire [11:0]              rom_data,
  input  wire [3:0]               mem_rdata,
  input  wire                     ss_regs_wren,
  input  wire cpu_6s46_pkg::cpu_regs_t ss_regs,
  output logic [12:0]             rom_addr,
  output cpu_6s46_pkg::ram_req_t  mem_req,
  output cpu_6s46_pkg::cpu_regs_t regs,
  output logic                    halted
);
  import cpu_6s46_pkg::*;

  localparam logic [1:0] step_fetch = 2'd0;
  localparam logic [1:0] step_decode = 2'd1;
  localparam logic [1:0] step_read = 2'd2;

  logic [1:0]  step;
  logic [11:0] ir;
  logic [11:0] instr;
  opcode_e     op;
  logic [1:0]  r_sel;
  logic [3:0]  imm;
  logic [7:0]  imm8;
  logic        needs_mem;
  logic        exec;
  logic [3:0]  src;
  logic [4:0]  sum;
  logic [3:0]  result;
  cpu_regs_t   regs_next;
  logic        halt_now;

  // ROM answers one cycle after the address
  assign rom_addr = regs.pc;

  // held word for the RAM read step
  always_ff @(posedge clk) begin
    if (step == step_decode) begin
      ir <= rom_data;
    end
  end

  assign instr = (step == step_read) ? ir : rom_data;

  always_comb begin
    casez (instr)
      12'b1110_00??_????: op = ld_ri;
      12'b1100_00??_????: op = add_ri;
      12'b0000_????_????: op = jp;
      12'b1011_????_????: op = ld_x;
      12'b1000_????_????: op = ld_y;
      12'b1111_1111_1011: op = nop5;
      12'b1111_1111_1000: op = halt;
      default:            op = illegal;
    endcase
  end

  assign r_sel = instr[5:4];
  assign imm = instr[3:0];
  assign imm8 = instr[7:0];

  // MX and MY operands take an extra cycle
  assign needs_mem = ((op == ld_ri) || (op == add_ri)) && r_sel[1];

  assign exec = ((step == step_decode) && !needs_mem) || (step == step_read);

  // operand r selects A, B, MX or MY
  always_comb begin
    case (r_sel)
      2'd0:    src = regs.a;
      2'd1:    src = regs.b;
      default: src = mem_rdata;
    endcase
  end

  assign sum = {1'b0, src} + {1'b0, imm};
  assign result = (op == add_ri) ? sum[3:0] : imm;

  always_comb begin
    mem_req.addr = r_sel[0] ? regs.y[7:0] : regs.x[7:0];
    mem_req.wdata = result;
    mem_req.wren = exec && needs_mem;
  end

  always_comb begin
    regs_next = regs;
    regs_next.pc = regs.pc + 13'd1;
    halt_now = 1'b0;
    case (op)
      ld_ri, add_ri: begin
        case (r_sel)
          2'd0:    regs_next.a = result;
          2'd1:    regs_next.b = result;
          default: begin
            // MX and MY go out on mem_req
          end
        endcase
        // LD keeps the flags
        if (op == add_ri) begin
          regs_next.carry = sum[4];
          regs_next.zero = (sum[3:0] == 4'd0);
        end
      end
      jp: begin
        regs_next.pc = {regs.pc[12:8], imm8};
      end
      ld_x: begin
        regs_next.x = {regs.x[11:8], imm8};
      end
      ld_y: begin
        regs_next.y = {regs.y[11:8], imm8};
      end
      halt: begin
        regs_next.pc = regs.pc;
        halt_now = 1'b1;
      end
      default: begin
        // nop5 and unknown words only step pc
      end
    endcase
  end

  // step sequencer
  always_ff @(posedge clk) begin
    if (reset_n) begin
      step <= step_fetch;
      halted <= 1'b0;
    end else if (!halted) begin
      case (step)
        step_fetch:  step <= step_decode;
        step_decode: step <= needs_mem ? step_read : step_fetch;
        default:     step <= step_fetch;
      endcase
      if (exec && halt_now) begin
        halted <= 1'b1;
      end
    end
  end

  // savestate load sticks even while reset is held
  always_ff @(posedge clk) begin
    if (ss_regs_wren) begin
      regs <= ss_regs;
    end else if (reset_n) begin
      regs <= '0;
    end else if (exec) begin
      regs <= regs_next;
    end
  end

endmodule

`default_nettype wire

// ==== source/cpu_6s46.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_6s46_settings.svh"

module cpu_6s46 (
  input  wire         clk,
  input  wire         reset_n,
  input  wire [11:0]  rom_data,
  input  wire [7:0]   ss_bus_addr,
  input  wire [31:0]  ss_bus_in,
  input  wire         ss_bus_wren,
  output logic [12:0] rom_addr,
  output logic [31:0] ss_bus_out,
  output logic        halted
);
  import cpu_6s46_pkg::*;

  ram_req_t                     mem_req;
  cpu_regs_t                    regs;
  cpu_regs_t                    ss_regs;
  logic                         ss_regs_wren;
  logic [3:0]                   mem_rdata;
  logic [`CPU_RAM_BANKS-1:0]    bank_ss_wren;
  logic [2:0]                   ss_row;
  logic [4*`CPU_BANK_DEPTH-1:0] bank_nibbles [`CPU_RAM_BANKS];

  cpu_6s46_core core (
    .clk          (clk),
    .reset_n      (reset_n),
    .rom_data     (rom_data),
    .mem_rdata    (mem_rdata),
    .ss_regs_wren (ss_regs_wren),
    .ss_regs      (ss_regs),
    .rom_addr     (rom_addr),
    .mem_req      (mem_req),
    .regs         (regs),
    .halted       (halted)
  );

  // every bank sees the core request and filters on its index
  for (genvar b = 0; b < `CPU_RAM_BANKS; b++) begin : bank_gen
    ram_bank #(
      .bank_index (b)
    ) bank (
      .clk      (clk),
      .core_req (mem_req),
      .ss_wren  (bank_ss_wren[b]),
      .ss_row   (ss_row),
      .ss_word  (ss_bus_in),
      .nibbles  (bank_nibbles[b])
    );
  end

  savestate_port ss_port (
    .clk          (clk),
    .reset_n      (reset_n),
    .ss_bus_addr  (ss_bus_addr),
    .ss_bus_in    (ss_bus_in),
    .ss_bus_wren  (ss_bus_wren),
    .regs         (regs),
    .mem_addr     (mem_req.addr),
    .bank_nibbles (bank_nibbles),
    .ss_bus_out   (ss_bus_out),
    .ss_regs_wren (ss_regs_wren),
    .ss_regs      (ss_regs),
    .bank_ss_wren (bank_ss_wren),
    .ss_row       (ss_row),
    .mem_rdata    (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== testbench/cpu_6s46_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_6s46_sva (
  input wire                         clk,
  input wire                         reset_n,
  input wire                         ss_bus_wren,
  input wire [12:0]                  rom_addr,
  input wire                         halted,
  input wire cpu_6s46_pkg::ram_req_t mem_req
);

  int unsigned assert_errors = 0;

  // pc clears unless a savestate write lands in the same reset cycle
  rom_addr_after_reset: assert property (@(posedge clk)
    (reset_n && !ss_bus_wren) |=> (rom_addr == 13'd0))
    else begin
      $error("rom_addr not zero after reset");
      assert_errors++;
    end

  halted_sticky: assert property (@(posedge clk) $fell(halted) |-> $past(reset_n))
    else begin
      $error("halted fell without reset");
      assert_errors++;
    end

  no_write_when_halted: assert property (@(posedge clk) halted |-> !mem_req.wren)
    else begin
      $error("core RAM write while halted");
      assert_errors++;
    end

endmodule

`default_nettype wire

// ==== testbench/cpu_6s46_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_6s46_tb;

  localparam int rom_words = 8192;
  localparam int max_entries = 256;
  localparam int halt_timeout = 200;
  localparam logic [3:0] kind_none = 4'h0;
  localparam logic [3:0] kind_test = 4'h1;
  localparam logic [3:0] kind_rom = 4'h2;
  localparam logic [3:0] kind_write = 4'h3;
  localparam logic [3:0] kind_read = 4'h4;
  localparam logic [11:0] halt_word = 12'hff8;
  localparam logic [11:0] nop5_word = 12'hffb;

  logic        clk;
  logic        reset_n;
  logic [11:0] rom_data;
  logic [7:0]  ss_bus_addr;
  logic [31:0] ss_bus_in;
  logic        ss_bus_wren;
  logic [12:0] rom_addr;
  logic [31:0] ss_bus_out;
  logic        halted;

  logic [11:0] rom [rom_words];
  logic [47:0] vectors [max_entries];
  logic [7:0]  write_addr [$];
  logic [31:0] write_data [$];
  logic [7:0]  read_addr [$];
  logic [31:0] read_data [$];
  logic [12:0] fetch_addr;
  integer      seed;
  int          mismatches;
  int          timeouts;
  int          vector_errors;
  int          tests_run;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ROM word appears 1 ns after the edge
  always @(posedge clk) begin
    fetch_addr = rom_addr;
    #1 rom_data = rom[fetch_addr];
  end

  cpu_6s46 UUT (
    .clk         (clk),
    .reset_n     (reset_n),
    .rom_data    (rom_data),
    .ss_bus_addr (ss_bus_addr),
    .ss_bus_in   (ss_bus_in),
    .ss_bus_wren (ss_bus_wren),
    .rom_addr    (rom_addr),
    .ss_bus_out  (ss_bus_out),
    .halted      (halted)
  );

  bind cpu_6s46 cpu_6s46_sva checks (
    .clk         (clk),
    .reset_n     (reset_n),
    .ss_bus_wren (ss_bus_wren),
    .rom_addr    (rom_addr),
    .halted      (halted),
    .mem_req     (mem_req)
  );

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input int num, input logic [7:0] addr,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch ss_bus_out addr 0x%02h in test %0d: expected 0x%08h, actual 0x%08h",
               addr, num, expected, actual);
      mismatches++;
    end
  endtask

  // HALT-free noise so a stray fetch never stops the core
  task automatic fill_rom_noise();
    logic [11:0] word;
    for (int i = 0; i < rom_words; i++) begin
      word = 12'($random(seed));
      if (word == halt_word) begin
        word = nop5_word;
      end
      rom[i] = word;
    end
  endtask

  task automatic run_test(input int num);
    int cycles;
    reset_n = 1'b1;
    ss_bus_wren = 1'b0;
    repeat (2) next_cycle();
    // savestate writes land while reset is still held
    for (int i = 0; i < write_addr.size(); i++) begin
      ss_bus_addr = write_addr[i];
      ss_bus_in = write_data[i];
      ss_bus_wren = 1'b1;
      next_cycle();
    end
    ss_bus_wren = 1'b0;
    reset_n = 1'b0;
    cycles = 0;
    while (!halted && cycles < halt_timeout) begin
      next_cycle();
      cycles++;
    end
    if (!halted) begin
      $display("test %0d: program never halted within %0d cycles", num, halt_timeout);
      timeouts++;
    end else begin
      // registered read takes one cycle
      for (int i = 0; i < read_addr.size(); i++) begin
        ss_bus_addr = read_addr[i];
        next_cycle();
        check_word(num, read_addr[i], read_data[i], ss_bus_out);
      end
    end
    tests_run++;
  endtask

  initial begin
    int         idx;
    int         num;
    logic [3:0] kind;
    seed = 32'hca4773b2;
    mismatches = 0;
    timeouts = 0;
    vector_errors = 0;
    tests_run = 0;
    reset_n = 1'b1;
    rom_data = '0;
    ss_bus_addr = '0;
    ss_bus_in = '0;
    ss_bus_wren = 1'b0;
    for (int i = 0; i < max_entries; i++) begin
      vectors[i] = '0;
    end
    $readmemh("testbench/cpu_6s46_vectors.txt", vectors);
    next_cycle();
    idx = 0;
    while (idx < max_entries && vectors[idx][47:44] == kind_test) begin
      num = int'(vectors[idx][31:0]);
      idx++;
      fill_rom_noise();
      write_addr.delete();
      write_data.delete();
      read_addr.delete();
      read_data.delete();
      while (idx < max_entries && vectors[idx][47:44] != kind_test &&
             vectors[idx][47:44] != kind_none) begin
        kind = vectors[idx][47:44];
        if (kind == kind_rom) begin
          rom[vectors[idx][43:32]] = vectors[idx][11:0];
        end else if (kind == kind_write) begin
          write_addr.push_back(vectors[idx][39:32]);
          write_data.push_back(vectors[idx][31:0]);
        end else if (kind == kind_read) begin
          read_addr.push_back(vectors[idx][39:32]);
          read_data.push_back(vectors[idx][31:0]);
        end else begin
          $display("vector entry %0d has unknown kind %0h", idx, kind);
          vector_errors++;
        end
        idx++;
      end
      run_test(num);
    end
    if (tests_run == 0) begin
      $display("no tests were found in the vector file");
      vector_errors++;
    end
    $display("%0d tests, %0d mismatches, %0d timeouts, %0d assertion failures, %0d vector errors",
             tests_run, mismatches, timeouts, UUT.checks.assert_errors, vector_errors);
    if (mismatches == 0 && timeouts == 0 && vector_errors == 0 &&
        UUT.checks.assert_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/cpu_6s46_vectors.txt ====
// columns: kind_addr_data, all hex
// kind 1 starts a test, 2 is a ROM word, 3 a savestate write, 4 an expected savestate read
// reset then HALT at 0
1_000_00000001
2_000_00000ff8
4_000_00000000
4_001_00000000
// LD and ADD on A and B
1_000_00000002
2_000_00000e09
2_001_00000e15
2_002_00000c13
2_003_00000c07
2_004_00000ff8
4_000_03800004
// MX and MY writes into banks 0 and 1
1_000_00000003
3_002_00000000
3_00a_00000000
2_000_00000b05
2_001_00000847
2_002_00000e2a
2_003_00000e3c
2_004_00000ff8
4_000_00000004
4_001_00470005
4_002_00a00000
4_00a_c0000000
// ADD MX on a preloaded nibble in bank 2
1_000_00000004
3_014_87656321
2_000_00000b93
2_001_00000c2d
2_002_00000ff8
4_000_01000002
4_001_00000093
4_014_87653321
// JP over a HALT
1_000_00000005
2_000_00000e03
2_001_00000005
2_002_00000ff8
2_005_00000ffb
2_006_00000c11
2_007_00000ff8
4_000_00130007
// registers preloaded under reset, register words go last
1_000_00000006
3_01a_00000000
3_01e_00000000
3_000_00b60000
3_001_00e400c2
2_000_00000c0a
2_001_00000c12
2_002_00000e27
2_003_00000e39
2_004_00000ff8
4_000_00d00004
4_001_00e400c2
4_01a_00000700
4_01e_00090000

// ==== files.f ====
+incdir+include
source/cpu_6s46_pkg.sv
source/ram_bank.sv
source/savestate_port.sv
source/cpu_6s46_core.sv
source/cpu_6s46.sv
testbench/cpu_6s46_sva.sv
testbench/cpu_6s46_tb.sv
